// File: src/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth = 8;   // Registers, buses and memory words

    typedef enum logic [7:0] {
        OpHalt = 8'h00, OpInc = 8'h01, OpDec = 8'h02, OpInv = 8'h03,
        OpJump = 8'h04, OpAdd = 8'h10, OpSub = 8'h20, OpMul = 8'h30,
        OpDiv  = 8'h40, OpRem = 8'h50, OpAnd = 8'h60, OpOr  = 8'h70,
        OpXor  = 8'h80, OpNand = 8'h90, OpNor = 8'hA0, OpXnor = 8'hB0
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluMul, AluDiv, AluRem,
        AluAnd, AluOr, AluXor, AluNand, AluNor, AluXnor,
        AluInvA,    // Unary invert ignores b
        AluZero     // Unknown opcodes
    } aluOpT;

    typedef enum logic [4:0] {
        Fetch0, Fetch1, Fetch2, Decode,
        LoadA0, LoadA1, LoadA2,
        LoadB0, LoadB1, LoadB2, LoadBOne,
        AluExec, JumpExec,
        StoreOp0, StoreOp1, StoreRes0, StoreRes1,
        Halt
    } stateT;

    typedef enum logic [2:0] {
        Bus1Pc, Bus1A, Bus1B, Bus1C, Bus1Result, Bus1Ir
    } bus1SelT;

    typedef enum logic [1:0] {
        Bus2Bus1, Bus2One, Bus2Mem, Bus2Alu
    } bus2SelT;

endpackage

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  aluOpT                aluOp,
    output logic [DataWidth-1:0] aluResult
);

    logic                 subtract;         // Selects a + ~b + 1
    logic [DataWidth-1:0] addend;           // b or ~b into the chain
    logic [DataWidth:0]   carry;            // Ripple carries, carry[0] is carry-in
    logic [DataWidth-1:0] sum;              // Adder output
    logic [DataWidth-1:0] product;          // Low byte of a * b
    logic [DataWidth-1:0] quotient;
    logic [DataWidth:0]   partial;          // Running remainder, one spare bit

    assign subtract = (aluOp == AluSub);
    assign addend   = subtract ? ~b : b;
    assign carry[0] = subtract;             // The +1 of two's complement

    // One full adder per bit
    for (genvar i = 0; i < DataWidth; i++) begin : gRipple
        assign sum[i]     = a[i] ^ addend[i] ^ carry[i];
        assign carry[i+1] = (a[i] & addend[i]) | (carry[i] & (a[i] ^ addend[i]));
    end

    // Shift-add, upper bits just fall off
    always_comb begin
        product = '0;
        for (int i = 0; i < DataWidth; i++) begin
            if (b[i]) product = product + (a << i);
        end
    end

    // Restoring division, MSB of dividend first
    always_comb begin
        quotient = '0;
        partial  = '0;
        for (int i = DataWidth - 1; i >= 0; i--) begin
            partial = {partial[DataWidth-1:0], a[i]};   // Bring down next bit
            if (partial >= {1'b0, b}) begin
                partial     = partial - {1'b0, b};
                quotient[i] = 1'b1;
            end                                      // Else restore, i.e. keep partial
        end
    end

    always_comb begin
        case (aluOp)
            AluAdd,
            AluSub:  aluResult = sum;
            AluMul:  aluResult = product;
            AluDiv:  aluResult = (b == '0) ? '1 : quotient;                // FF on zero divisor
            AluRem:  aluResult = (b == '0) ? '1 : partial[DataWidth-1:0];
            AluAnd:  aluResult = a & b;
            AluOr:   aluResult = a | b;
            AluXor:  aluResult = a ^ b;
            AluNand: aluResult = ~(a & b);
            AluNor:  aluResult = ~(a | b);
            AluXnor: aluResult = ~(a ^ b);
            AluInvA: aluResult = ~a;
            default: aluResult = '0;        // AluZero
        endcase
    end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  opcodeT  ir,
    output logic    irLoad,
    output logic    marLoad,
    output logic    pcInc,
    output logic    pcJump,
    output logic    aLoad,
    output logic    bLoad,
    output logic    cLoad,
    output logic    resultInc,
    output logic    memWrite,
    output bus1SelT bus1Sel,
    output bus2SelT bus2Sel,
    output aluOpT   aluOp,
    output logic    done
);

    stateT state;
    stateT nextState;
    logic  isUnary;     // inc, dec, invert
    logic  isJump;

    assign isUnary = (ir == OpInc) || (ir == OpDec) || (ir == OpInv);
    assign isJump  = (ir == OpJump);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= Fetch0;
            done  <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState == Halt) done <= 1'b1;    // Sticky until reset
        end
    end

    always_comb begin
        case (state)
            Fetch0:    nextState = Fetch1;
            Fetch1:    nextState = Fetch2;
            Fetch2:    nextState = Decode;
            Decode: begin
                if (ir == OpHalt) nextState = Halt;
                else if (isJump)  nextState = LoadB0;   // Offset goes straight to B
                else              nextState = LoadA0;
            end
            LoadA0:    nextState = LoadA1;
            LoadA1:    nextState = LoadA2;
            LoadA2:    nextState = isUnary ? LoadBOne : LoadB0;
            LoadB0:    nextState = LoadB1;
            LoadB1:    nextState = LoadB2;
            LoadB2:    nextState = isJump ? JumpExec : AluExec;
            LoadBOne:  nextState = AluExec;
            AluExec:   nextState = StoreOp0;
            JumpExec:  nextState = StoreOp0;
            StoreOp0:  nextState = StoreOp1;
            StoreOp1:  nextState = StoreRes0;
            StoreRes0: nextState = StoreRes1;
            StoreRes1: nextState = Fetch0;
            Halt:      nextState = Halt;
            default:   nextState = Fetch0;
        endcase
    end

    // Moore outputs, everything idle by default
    always_comb begin
        irLoad    = 1'b0;
        marLoad   = 1'b0;
        pcInc     = 1'b0;
        pcJump    = 1'b0;
        aLoad     = 1'b0;
        bLoad     = 1'b0;
        cLoad     = 1'b0;
        resultInc = 1'b0;
        memWrite  = 1'b0;
        bus1Sel   = Bus1Pc;
        bus2Sel   = Bus2Bus1;
        case (state)
            Fetch0, LoadA0, LoadB0: marLoad = 1'b1;     // MAR <= PC
            Fetch1, LoadA1, LoadB1: pcInc = 1'b1;       // Memory latches address meanwhile
            Fetch2: begin
                irLoad  = 1'b1;
                bus2Sel = Bus2Mem;
            end
            LoadA2: begin
                aLoad   = 1'b1;
                bus2Sel = Bus2Mem;
            end
            LoadB2: begin
                bLoad   = 1'b1;
                bus2Sel = Bus2Mem;
            end
            LoadBOne: begin     // Invert passes here too, B is unused then
                bLoad   = 1'b1;
                bus2Sel = Bus2One;
            end
            AluExec: begin
                cLoad   = 1'b1;
                bus2Sel = Bus2Alu;
            end
            JumpExec: begin
                pcJump  = 1'b1;     // PC already points past the offset byte
                bus1Sel = Bus1B;
            end
            StoreOp0, StoreRes0: begin
                marLoad = 1'b1;
                bus1Sel = Bus1Result;
            end
            StoreOp1: begin
                memWrite  = 1'b1;
                resultInc = 1'b1;
                bus1Sel   = Bus1Ir;
            end
            StoreRes1: begin
                memWrite  = 1'b1;
                resultInc = 1'b1;
                bus1Sel   = isJump ? Bus1B : Bus1C;     // Jump reports its offset
            end
            default: ;
        endcase
    end

    // ALU function from opcode
    always_comb begin
        case (ir)
            OpInc, OpAdd: aluOp = AluAdd;
            OpDec, OpSub: aluOp = AluSub;
            OpInv:        aluOp = AluInvA;
            OpMul:        aluOp = AluMul;
            OpDiv:        aluOp = AluDiv;
            OpRem:        aluOp = AluRem;
            OpAnd:        aluOp = AluAnd;
            OpOr:         aluOp = AluOr;
            OpXor:        aluOp = AluXor;
            OpNand:       aluOp = AluNand;
            OpNor:        aluOp = AluNor;
            OpXnor:       aluOp = AluXnor;
            default:      aluOp = AluZero;  // Unknown opcodes yield 00
        endcase
    end

endmodule

// File: src/dataPath.sv
`timescale 1ns/1ps

module dataPath import cpuPkg::*; #(
    parameter logic [DataWidth-1:0] ResultBase = 8'h80
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 irLoad,
    input  logic                 marLoad,
    input  logic                 pcInc,
    input  logic                 pcJump,
    input  logic                 aLoad,
    input  logic                 bLoad,
    input  logic                 cLoad,
    input  logic                 resultInc,
    input  logic                 memWrite,
    input  bus1SelT              bus1Sel,
    input  bus2SelT              bus2Sel,
    input  logic [DataWidth-1:0] memReadData,
    input  logic [DataWidth-1:0] aluResult,
    output opcodeT               ir,
    output logic [DataWidth-1:0] a,
    output logic [DataWidth-1:0] b,
    output logic [DataWidth-1:0] memAddress,
    output logic [DataWidth-1:0] memWriteData
);

    logic [DataWidth-1:0] c;            // ALU result holding register
    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] mar;
    logic [DataWidth-1:0] resultPtr;    // Next free byte of result area
    logic [DataWidth-1:0] bus1;
    logic [DataWidth-1:0] bus2;

    always_comb begin
        case (bus1Sel)
            Bus1Pc:     bus1 = pc;
            Bus1A:      bus1 = a;
            Bus1B:      bus1 = b;
            Bus1C:      bus1 = c;
            Bus1Result: bus1 = resultPtr;
            Bus1Ir:     bus1 = ir;
            default:    bus1 = pc;
        endcase
    end

    always_comb begin
        case (bus2Sel)
            Bus2Bus1: bus2 = bus1;
            Bus2One:  bus2 = DataWidth'(1);   // Inc/dec step
            Bus2Mem:  bus2 = memReadData;
            default:  bus2 = aluResult;       // Bus2Alu
        endcase
    end

    // Control-related registers
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ir        <= OpHalt;
            pc        <= '0;
            mar       <= '0;
            resultPtr <= ResultBase;
        end else begin
            if (irLoad)  ir  <= opcodeT'(bus2);     // Unknown codes kept as is
            if (marLoad) mar <= bus2;
            if (pcJump)     pc <= pc + bus2;        // Wraps modulo 256
            else if (pcInc) pc <= pc + DataWidth'(1);
            if (resultInc) resultPtr <= resultPtr + DataWidth'(1);
        end
    end

    // Operand and result bytes
    always_ff @(posedge clock) begin
        if (aLoad) a <= bus2;
        if (bLoad) b <= bus2;
        if (cLoad) c <= bus2;
    end

    assign memAddress   = mar;
    assign memWriteData = memWrite ? bus1 : '0;   // Quiet bus between writes

endmodule

// File: src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
    parameter logic [DataWidth-1:0] ResultBase = 8'h80   // Start of result area
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [DataWidth-1:0] memReadData,
    output logic [DataWidth-1:0] memAddress,
    output logic [DataWidth-1:0] memWriteData,
    output logic                 memWrite,
    output logic                 done
);

    opcodeT               ir;
    logic [DataWidth-1:0] a, b, aluResult;
    logic                 irLoad, marLoad, pcInc, pcJump;
    logic                 aLoad, bLoad, cLoad, resultInc;
    bus1SelT              bus1Sel;
    bus2SelT              bus2Sel;
    aluOpT                aluOp;

    controlUnit control_i (
        .clock, .reset, .ir,
        .irLoad, .marLoad, .pcInc, .pcJump, .aLoad, .bLoad, .cLoad, .resultInc,
        .memWrite, .bus1Sel, .bus2Sel, .aluOp, .done
    );

    dataPath #(.ResultBase(ResultBase)) dataPath_i (
        .clock, .reset,
        .irLoad, .marLoad, .pcInc, .pcJump, .aLoad, .bLoad, .cLoad, .resultInc,
        .memWrite, .bus1Sel, .bus2Sel,
        .memReadData, .aluResult,
        .ir, .a, .b, .memAddress, .memWriteData
    );

    aluUnit alu_i (
        .a, .b, .aluOp, .aluResult
    );

endmodule

// File: testbench/cpu_asserts.sv
`timescale 1ns/1ps

module cpuAsserts (
    input logic clock,
    input logic reset,
    input logic memWrite,
    input logic done
);

    logic writeWhileDone  = 1'b0;   // Sticky failure flags
    logic doneFell        = 1'b0;
    logic writeAfterReset = 1'b0;

    // Halted core stays off the bus
    noWriteWhileDone: assert property (@(posedge clock) disable iff (!reset)
        !(memWrite && done))
        else begin
            writeWhileDone = 1'b1;
            $error("memWrite high while done is set");
        end

    doneHolds: assert property (@(posedge clock) disable iff (!reset)
        done |=> done)
        else begin
            doneFell = 1'b1;
            $error("done fell without reset");
        end

    // First cycle out of reset is Fetch0
    quietAfterReset: assert property (@(posedge clock)
        $rose(reset) |-> !memWrite)
        else begin
            writeAfterReset = 1'b1;
            $error("memWrite high in the first cycle after reset");
        end

endmodule

bind cpuTop cpuAsserts cpuAsserts_i (
    .clock, .reset, .memWrite, .done
);

// File: testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    localparam logic [DataWidth-1:0] ResultBase   = 8'h80;  // Result area start
    localparam logic [DataWidth-1:0] ExpectedBase = 8'hC0;  // Expected bytes in the image
    localparam logic [DataWidth-1:0] CountAddress = 8'hFF;  // Expected number of writes

    logic                 clock;
    logic                 reset;
    logic [DataWidth-1:0] memReadData;
    logic [DataWidth-1:0] memAddress;
    logic [DataWidth-1:0] memWriteData;
    logic                 memWrite;
    logic                 done;

    logic [DataWidth-1:0] mem [256];        // Program, results, expected bytes
    logic [DataWidth-1:0] latchedAddress;   // Address from the previous cycle
    logic [DataWidth-1:0] expectedCount;
    int                   programBytes;
    int                   writeCount;       // Result bytes seen so far

    cpuTop #(.ResultBase(ResultBase)) dut_i (
        .clock, .reset, .memReadData, .memAddress, .memWriteData, .memWrite, .done
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;          // 4 ns period
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input logic [DataWidth-1:0] actual,
                              input logic [DataWidth-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("Error at %0d ns: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    // Program ends with the halt just after its last nonzero byte
    function automatic int findProgramLength();
        int last;
        last = -1;
        for (int i = 0; i < ResultBase; i++) begin
            if (mem[i] != '0) last = i;
        end
        return last + 2;
    endfunction

    // Each write must land on the next result slot with the next expected byte
    task automatic storeWrite();
        if (memAddress < ResultBase || memAddress >= ExpectedBase) begin
            failRun($sformatf("Write to address %h lies outside the result area",
                              memAddress));
        end
        if (writeCount >= int'(expectedCount)) begin
            failRun("More result writes than the input file expects");
        end
        checkValue("memAddress", memAddress, 8'(int'(ResultBase) + writeCount));
        checkValue("memWriteData", memWriteData, mem[int'(ExpectedBase) + writeCount]);
        mem[memAddress] = memWriteData;
        writeCount++;
    endtask

    // Read data one cycle behind the address
    always @(posedge clock) begin
        #1;
        memReadData    = mem[latchedAddress];
        latchedAddress = memAddress;
    end

    // Sample mid-cycle where outputs are settled
    always @(negedge clock) begin
        if (reset && memWrite) storeWrite();
        if (dut_i.cpuAsserts_i.writeWhileDone || dut_i.cpuAsserts_i.doneFell
                || dut_i.cpuAsserts_i.writeAfterReset) begin
            failRun("A concurrent assertion on the cpuTop ports failed");
        end
    end

    // Watchdog scaled by program size
    initial begin
        #1;
        repeat (20 * programBytes + 100) @(posedge clock);
        failRun($sformatf("Timeout, done did not rise within %0d cycles",
                          20 * programBytes + 100));
    end

    initial begin
        reset          = 1'b0;
        memReadData    = '0;
        latchedAddress = '0;
        writeCount     = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        $readmemh("testbench/programInput.txt", mem);
        expectedCount = mem[CountAddress];
        programBytes  = findProgramLength();
        if (expectedCount == '0) failRun("The input file holds no expected result bytes");

        repeat (5) begin                    // Outputs quiet while in reset
            @(posedge clock);
            #1;
            checkValue("done", 8'(done), 8'h00);
            checkValue("memWrite", 8'(memWrite), 8'h00);
        end
        reset = 1'b1;

        @(posedge clock);                   // Fetch0 copies PC into MAR
        @(negedge clock);
        checkValue("memAddress", memAddress, 8'h00);

        while (!done) begin
            @(negedge clock);
        end
        checkValue("result write count", 8'(writeCount), expectedCount);
        repeat (3) @(negedge clock);
        checkValue("done", 8'(done), 8'h01);   // Still halted
        $display("all tests passed");
        $finish;
    end

endmodule

// File: testbench/programInput.txt
// Program bytes (opcode then operands) from 00, expected result pairs
// (opcode, result) from C0, expected count of result bytes at FF; all hex
@00
10 07 05    // add 7 + 5
20 03 05    // sub wraps to FE
30 0D 15    // mul 111, low byte 11
40 64 07    // div 100 / 7
50 64 07    // rem 100 % 7
40 2A 00    // div by zero
50 2A 00    // rem by zero
60 CC AA    // and
70 CC AA    // or
80 CC AA    // xor
90 CC AA    // nand
A0 CC AA    // nor
B0 CC AA    // xnor
01 FF       // inc wraps to 00
02 00       // dec wraps to FF
03 5A       // invert
04 03       // jump over the next add
10 11 11    // skipped
40 F0 03    // div with large quotient
30 FF FF    // mul, low byte 01
C5 12 34    // unknown opcode gives 00
00          // halt
@C0
10 0C 20 FE 30 11 40 0E 50 02 40 FF 50 FF 60 88
70 EE 80 66 90 77 A0 11 B0 99 01 00 02 FF 03 A5
04 03 40 50 30 01 C5 00
@FF
28

// File: tb.f
src/cpuPkg.sv
src/aluUnit.sv
src/controlUnit.sv
src/dataPath.sv
src/cpuTop.sv
testbench/cpu_asserts.sv
testbench/cpuTb.sv

// File: Makefile
TOP := cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
